//--- Makefile
# Verilator build and run of the instruction cache testbench

LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module icache_tb \
		-Mdir build -f filelist.f
	-./build/Vicache_tb > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG) || ! grep -q "RESULT: PASS" $(LOG); then \
		echo "Simulation failed"; exit 1; \
	fi
	@echo "Simulation passed"

clean:
	rm -rf build $(LOG)

//--- filelist.f
hdl/cpu_pkg.sv
hdl/cache_pkg.sv
hdl/line_store.sv
hdl/cache_way.sv
hdl/icache_controller.sv
hdl/way_select.sv
hdl/icache_top.sv
test/main_memory_model.sv
test/icache_tb.sv

//--- hdl/cache_pkg.sv
package cache_pkg;

    // Address bits below the word
    localparam int BYTE_OFFSET_WIDTH = 2;

    // ------------------------------
    // Address field widths
    // ------------------------------

    // Word select inside a line
    function automatic int block_width(input int blocks);
        return $clog2(blocks);
    endfunction

    // Line select inside a way
    function automatic int index_width(input int lines);
        return $clog2(lines);
    endfunction

    // Whatever is left above index and block
    function automatic int tag_width(input int blocks, input int lines);
        return cpu_pkg::ADDR_WIDTH - BYTE_OFFSET_WIDTH
               - index_width(lines) - block_width(blocks);
    endfunction

endpackage

//--- hdl/cache_way.sv
`timescale 1ns/100ps

module cache_way #(
    parameter int BLOCKS = 4,   // Words per line
    parameter int LINES  = 16   // Lines in this way
) (
    input  logic                                          i_clock,
    input  logic                                          i_rst_n,
    input  logic                                          i_clear,        // Flush all lines
    input  logic                                          i_we,           // Line write
    input  logic [cache_pkg::index_width(LINES)-1:0]      i_lookup_index,
    input  logic [cache_pkg::tag_width(BLOCKS, LINES)-1:0] i_lookup_tag,
    input  logic [cache_pkg::index_width(LINES)-1:0]      i_fill_index,
    input  logic [cache_pkg::tag_width(BLOCKS, LINES)-1:0] i_fill_tag,
    input  logic [BLOCKS*cpu_pkg::INST_WIDTH-1:0]         i_fill_line,
    output logic                                          o_hit,          // Valid and tag match
    output logic [BLOCKS*cpu_pkg::INST_WIDTH-1:0]         o_line          // Line at lookup index
);

    import cpu_pkg::*;
    import cache_pkg::*;

    localparam int TAG_W   = tag_width(BLOCKS, LINES);
    localparam int LINE_W  = BLOCKS * INST_WIDTH;

    typedef logic [TAG_W-1:0]  tag_t;
    typedef logic [LINE_W-1:0] line_t;

    logic [LINES-1:0] valid;       // One bit per line
    tag_t             stored_tag;  // Tag at lookup index

    // ------------------------------
    // Tag and data arrays
    // ------------------------------

    line_store #(
        .payload_t (tag_t),
        .DEPTH     (LINES)
    ) u_tag_store (
        .i_clock (i_clock),
        .i_we    (i_we),
        .i_waddr (i_fill_index),
        .i_wdata (i_fill_tag),
        .i_raddr (i_lookup_index),
        .o_rdata (stored_tag)
    );

    line_store #(
        .payload_t (line_t),
        .DEPTH     (LINES)
    ) u_data_store (
        .i_clock (i_clock),
        .i_we    (i_we),
        .i_waddr (i_fill_index),
        .i_wdata (i_fill_line),
        .i_raddr (i_lookup_index),
        .o_rdata (o_line)
    );

    // ------------------------------
    // Valid bits
    // ------------------------------

    always_ff @(posedge i_clock) begin
        if (!i_rst_n || i_clear) begin
            valid <= '0;                    // Nothing resident
        end else if (i_we) begin
            valid[i_fill_index] <= 1'b1;    // Line now usable
        end
    end

    // Hit needs a live line and a matching tag
    assign o_hit = valid[i_lookup_index] && (stored_tag == i_lookup_tag);

    // Controller only flushes while idle and only fills while refilling
    a_no_we_on_clear: assert property (
        @(posedge i_clock) disable iff (!i_rst_n) !(i_we && i_clear)
    ) else $error("cache_way write and clear in the same cycle");

endmodule

//--- hdl/cpu_pkg.sv
package cpu_pkg;

    // ------------------------------
    // Fetch port widths
    // ------------------------------

    localparam int INST_WIDTH = 32;  // One instruction word
    localparam int ADDR_WIDTH = 32;  // Byte addressing

    // Instruction word as seen on the fetch port
    typedef logic [INST_WIDTH-1:0] inst_t;

    // Byte address, two low bits zero for aligned fetches
    typedef logic [ADDR_WIDTH-1:0] inst_addr_t;

endpackage

//--- hdl/icache_controller.sv
`timescale 1ns/100ps

module icache_controller #(
    parameter int NUM_WAYS = 2,   // Ways to refill into
    parameter int BLOCKS   = 4,   // Words per line
    parameter int LINES    = 16   // Lines per way
) (
    input  logic                                           i_clock,
    input  logic                                           i_rst_n,
    input  logic                                           i_rd,          // Fetch request
    input  logic                                           i_flush,       // Invalidate strobe
    input  logic                                           i_hit,         // Lookup result
    input  logic [cache_pkg::tag_width(BLOCKS, LINES)-1:0] i_tag,         // Lookup tag
    input  logic [cache_pkg::index_width(LINES)-1:0]       i_index,       // Lookup index
    input  cpu_pkg::inst_t                                 i_mem_data,    // Word from memory
    output logic [cache_pkg::tag_width(BLOCKS, LINES)-1:0] o_fill_tag,
    output logic [cache_pkg::index_width(LINES)-1:0]       o_fill_index,
    output logic [cache_pkg::block_width(BLOCKS)-1:0]      o_fill_block,  // Word being fetched
    output logic                                           o_mem_re,
    output logic [NUM_WAYS-1:0]                            o_way_we,      // Victim write strobe
    output logic [BLOCKS*cpu_pkg::INST_WIDTH-1:0]          o_fill_line,   // Assembled line
    output logic                                           o_clear,       // Flush to all ways
    output logic                                           o_busy         // CPU stall
);

    import cpu_pkg::*;
    import cache_pkg::*;

    localparam int BLOCK_W  = block_width(BLOCKS);
    localparam int VICTIM_W = (NUM_WAYS > 1) ? $clog2(NUM_WAYS) : 1;

    localparam logic [BLOCK_W-1:0]  LAST_BLOCK = BLOCK_W'(BLOCKS - 1);
    localparam logic [VICTIM_W-1:0] LAST_WAY   = VICTIM_W'(NUM_WAYS - 1);

    typedef enum logic {
        S_IDLE,    // Serving hits
        S_REFILL   // Fetching a line
    } state_t;

    state_t               state;
    logic [BLOCK_W-1:0]   block_cnt;   // Refill beat
    logic [VICTIM_W-1:0]  victim;      // Round-robin pointer
    inst_t [BLOCKS-2:0]   fill_buf;    // Words 0 to BLOCKS-2
    logic                 miss;        // Start of refill
    logic                 last_beat;   // Final word arriving

    // ------------------------------
    // Decode
    // ------------------------------

    // Flush wins over a miss in the same cycle
    assign miss      = (state == S_IDLE) && i_rd && !i_hit && !i_flush;
    assign last_beat = (state == S_REFILL) && (block_cnt == LAST_BLOCK);

    // ------------------------------
    // Refill FSM
    // ------------------------------

    always_ff @(posedge i_clock) begin
        if (!i_rst_n) begin
            state     <= S_IDLE;
            block_cnt <= '0;
            victim    <= '0;   // Way 0 goes first
        end else begin
            case (state)
                S_IDLE: begin
                    if (miss) begin
                        state     <= S_REFILL;
                        block_cnt <= '0;
                    end
                end
                S_REFILL: begin
                    block_cnt <= block_cnt + 1'b1;  // Wraps to zero after the last word
                    if (last_beat) begin
                        state  <= S_IDLE;
                        victim <= (victim == LAST_WAY) ? '0 : victim + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // Miss address and early words
    always_ff @(posedge i_clock) begin
        if (miss) begin
            o_fill_tag   <= i_tag;     // Held for the whole refill
            o_fill_index <= i_index;
        end
        if ((state == S_REFILL) && !last_beat) begin
            fill_buf[block_cnt] <= i_mem_data;
        end
    end

    // ------------------------------
    // Outputs
    // ------------------------------

    assign o_busy       = (state == S_REFILL);
    assign o_mem_re     = (state == S_REFILL);            // One word per refill cycle
    assign o_fill_block = block_cnt;
    assign o_clear      = (state == S_IDLE) && i_flush;   // Held off during refill
    assign o_fill_line  = {i_mem_data, fill_buf};         // Last word straight from memory

    // Strobe the victim way on the last beat only
    always_comb begin
        o_way_we = '0;
        if (last_beat) begin
            o_way_we[victim] = 1'b1;
        end
    end

    a_way_we_onehot: assert property (
        @(posedge i_clock) disable iff (!i_rst_n) $onehot0(o_way_we)
    ) else $error("icache_controller writes more than one way");

endmodule

//--- hdl/icache_top.sv
`timescale 1ns/100ps

module icache_top #(
    parameter int NUM_WAYS = 2,   // Associativity
    parameter int BLOCKS   = 4,   // Words per line
    parameter int LINES    = 16   // Lines per way
) (
    input  logic                i_clock,
    input  logic                i_rst_n,
    input  cpu_pkg::inst_addr_t i_addr,      // Fetch byte address
    input  logic                i_rd,        // Fetch request
    input  logic                i_flush,     // Invalidate all lines
    output cpu_pkg::inst_t      o_inst,      // Fetched word
    output logic                o_hit,       // o_inst valid
    output logic                o_busy,      // Refill under way
    output cpu_pkg::inst_addr_t o_mem_addr,  // Refill byte address
    output logic                o_mem_re,    // Memory read strobe
    input  cpu_pkg::inst_t      i_mem_data   // Memory word, same cycle
);

    import cpu_pkg::*;
    import cache_pkg::*;

    localparam int BLOCK_W = block_width(BLOCKS);
    localparam int INDEX_W = index_width(LINES);
    localparam int TAG_W   = tag_width(BLOCKS, LINES);
    localparam int LINE_W  = BLOCKS * INST_WIDTH;

    // Lookup fields
    logic [TAG_W-1:0]   lookup_tag;
    logic [INDEX_W-1:0] lookup_index;
    logic [BLOCK_W-1:0] lookup_block;

    // Refill side
    logic [TAG_W-1:0]    fill_tag;
    logic [INDEX_W-1:0]  fill_index;
    logic [BLOCK_W-1:0]  fill_block;
    logic [LINE_W-1:0]   fill_line;
    logic [NUM_WAYS-1:0] way_we;
    logic                clear;

    // Way outputs
    logic [NUM_WAYS-1:0]             way_hit;
    logic [NUM_WAYS-1:0][LINE_W-1:0] way_lines;

    // ------------------------------
    // Address split
    // ------------------------------

    assign lookup_block = i_addr[BYTE_OFFSET_WIDTH +: BLOCK_W];
    assign lookup_index = i_addr[BYTE_OFFSET_WIDTH + BLOCK_W +: INDEX_W];
    assign lookup_tag   = i_addr[ADDR_WIDTH-1 -: TAG_W];

    // Back to a byte address for memory
    assign o_mem_addr = {fill_tag, fill_index, fill_block, {BYTE_OFFSET_WIDTH{1'b0}}};

    // ------------------------------
    // Controller
    // ------------------------------

    icache_controller #(
        .NUM_WAYS (NUM_WAYS),
        .BLOCKS   (BLOCKS),
        .LINES    (LINES)
    ) u_controller (
        .i_clock      (i_clock),
        .i_rst_n      (i_rst_n),
        .i_rd         (i_rd),
        .i_flush      (i_flush),
        .i_hit        (o_hit),
        .i_tag        (lookup_tag),
        .i_index      (lookup_index),
        .i_mem_data   (i_mem_data),
        .o_fill_tag   (fill_tag),
        .o_fill_index (fill_index),
        .o_fill_block (fill_block),
        .o_mem_re     (o_mem_re),
        .o_way_we     (way_we),
        .o_fill_line  (fill_line),
        .o_clear      (clear),
        .o_busy       (o_busy)
    );

    // ------------------------------
    // Ways
    // ------------------------------

    for (genvar w = 0; w < NUM_WAYS; w++) begin : g_way
        cache_way #(
            .BLOCKS (BLOCKS),
            .LINES  (LINES)
        ) u_way (
            .i_clock        (i_clock),
            .i_rst_n        (i_rst_n),
            .i_clear        (clear),
            .i_we           (way_we[w]),   // Only the victim writes
            .i_lookup_index (lookup_index),
            .i_lookup_tag   (lookup_tag),
            .i_fill_index   (fill_index),
            .i_fill_tag     (fill_tag),
            .i_fill_line    (fill_line),
            .o_hit          (way_hit[w]),
            .o_line         (way_lines[w])
        );
    end

    // Hit combine and word pick
    way_select #(
        .NUM_WAYS (NUM_WAYS),
        .BLOCKS   (BLOCKS)
    ) u_way_select (
        .i_way_hit   (way_hit),
        .i_way_lines (way_lines),
        .i_block     (lookup_block),
        .i_rd        (i_rd),
        .o_hit       (o_hit),
        .o_inst      (o_inst)
    );

endmodule

//--- hdl/line_store.sv
`timescale 1ns/100ps

module line_store #(
    parameter type payload_t = logic,  // Stored entry
    parameter int  DEPTH     = 16      // Number of entries
) (
    input  logic                     i_clock,
    input  logic                     i_we,       // Write strobe
    input  logic [$clog2(DEPTH)-1:0] i_waddr,    // Write entry
    input  payload_t                 i_wdata,    // Write payload
    input  logic [$clog2(DEPTH)-1:0] i_raddr,    // Read entry
    output payload_t                 o_rdata     // Read payload, no latency
);

    // Register array
    payload_t mem [DEPTH];

    // ------------------------------
    // Write port
    // ------------------------------

    always_ff @(posedge i_clock) begin
        if (i_we) begin
            mem[i_waddr] <= i_wdata;  // Lands at the edge
        end
    end

    // ------------------------------
    // Read port
    // ------------------------------

    // Same-cycle lookup for the hit path
    assign o_rdata = mem[i_raddr];

    // Writes stay inside the array
    a_waddr_range: assert property (
        @(posedge i_clock) i_we |-> (int'(i_waddr) < DEPTH)
    ) else $error("line_store write address %0d beyond depth %0d", i_waddr, DEPTH);

endmodule

//--- hdl/way_select.sv
`timescale 1ns/100ps

module way_select #(
    parameter int NUM_WAYS = 2,   // Ways to combine
    parameter int BLOCKS   = 4    // Words per line
) (
    input  logic [NUM_WAYS-1:0]                               i_way_hit,    // Per-way hit
    input  logic [NUM_WAYS-1:0][BLOCKS*cpu_pkg::INST_WIDTH-1:0] i_way_lines,  // Per-way line
    input  logic [cache_pkg::block_width(BLOCKS)-1:0]         i_block,      // Word in line
    input  logic                                              i_rd,         // Fetch request
    output logic                                              o_hit,
    output cpu_pkg::inst_t                                    o_inst
);

    import cpu_pkg::*;

    localparam int LINE_W = BLOCKS * INST_WIDTH;

    logic [LINE_W-1:0]        hit_line;   // Line of the hitting way
    inst_t [BLOCKS-1:0]       words;      // Same line by word
    logic                     any_hit;

    // ------------------------------
    // Way mux
    // ------------------------------

    // AND-OR mux since at most one way hits
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (i_way_hit[w]) begin
                hit_line = hit_line | i_way_lines[w];
            end
        end
    end

    assign any_hit = |i_way_hit;

    // ------------------------------
    // Word mux
    // ------------------------------

    assign words  = hit_line;                        // Word 0 in the low bits
    assign o_hit  = any_hit && i_rd;                 // Only reported on a fetch
    assign o_inst = o_hit ? words[i_block] : '0;     // Zero when nothing hits

    // A refill never duplicates a resident tag
    a_single_hit: assert property (
        @(i_way_hit) $onehot0(i_way_hit)
    ) else $error("way_select more than one way hits");

endmodule

//--- test/icache_tb.sv
`timescale 1ns/100ps

module icache_tb;

    localparam int NUM_WAYS   = 2;
    localparam int BLOCKS     = 4;
    localparam int LINES      = 16;
    localparam int BLOCK_BITS = $clog2(BLOCKS);
    localparam int INDEX_BITS = $clog2(LINES);
    localparam int TIMEOUT    = 50;    // Cycles per wait

    logic        clock;
    logic        rst_n;
    logic [31:0] addr;
    logic        rd;
    logic        flush;
    logic [31:0] inst;
    logic        hit;
    logic        busy;
    logic [31:0] mem_addr;
    logic        mem_re;
    logic [31:0] mem_data;

    // Reference model state
    logic [31:0] ref_tag   [NUM_WAYS][LINES];
    logic        ref_valid [NUM_WAYS][LINES];
    int          ref_ptr;                     // Next victim

    int          error_count;
    int          tests_run;
    int          tests_failed;
    logic [31:0] rng_state;

    icache_top #(
        .NUM_WAYS (NUM_WAYS),
        .BLOCKS   (BLOCKS),
        .LINES    (LINES)
    ) UUT (
        .i_clock    (clock),
        .i_rst_n    (rst_n),
        .i_addr     (addr),
        .i_rd       (rd),
        .i_flush    (flush),
        .o_inst     (inst),
        .o_hit      (hit),
        .o_busy     (busy),
        .o_mem_addr (mem_addr),
        .o_mem_re   (mem_re),
        .i_mem_data (mem_data)
    );

    main_memory_model u_memory (
        .i_addr (mem_addr),
        .i_re   (mem_re),
        .o_data (mem_data)
    );

    initial begin
        clock = 1'b0;
        forever #50 clock = ~clock;   // 100 ns period
    end

    // ------------------------------
    // Reference model
    // ------------------------------

    // Memory word for a byte address
    function automatic logic [31:0] expected_word(input logic [31:0] a);
        return ((a >> 2) * 32'h9E3779B1) ^ 32'hA5A5A5A5;
    endfunction

    function automatic int index_of(input logic [31:0] a);
        return int'((a >> (2 + BLOCK_BITS)) % LINES);
    endfunction

    function automatic logic [31:0] tag_of(input logic [31:0] a);
        return a >> (2 + BLOCK_BITS + INDEX_BITS);
    endfunction

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Way holding the address, or -1
    function automatic int ref_lookup(input logic [31:0] a);
        int found;
        found = -1;
        for (int w = 0; w < NUM_WAYS; w++) begin
            if (ref_valid[w][index_of(a)] && ref_tag[w][index_of(a)] == tag_of(a)) begin
                found = w;
            end
        end
        return found;
    endfunction

    function automatic void ref_fill(input logic [31:0] a);
        ref_tag[ref_ptr][index_of(a)]   = tag_of(a);
        ref_valid[ref_ptr][index_of(a)] = 1'b1;
        ref_ptr = (ref_ptr + 1) % NUM_WAYS;   // Round robin
    endfunction

    function automatic void ref_clear();
        for (int w = 0; w < NUM_WAYS; w++) begin
            for (int l = 0; l < LINES; l++) begin
                ref_valid[w][l] = 1'b0;
            end
        end
    endfunction

    function automatic void report_mismatch(input string msg);
        $display("FAIL %0t: %s", $time, msg);
        error_count++;
    endfunction

    function automatic void report_timeout(input string what);
        $display("Timeout: gave up after %0d cycles waiting for %s", TIMEOUT, what);
        error_count++;
    endfunction

    // Word check on every hit, sampled mid-cycle
    always @(negedge clock) begin
        if (rst_n && hit) begin
            if (inst !== expected_word(addr)) begin
                report_mismatch($sformatf("o_inst %h at %h, expected %h",
                                          inst, addr, expected_word(addr)));
            end
        end
    end

    // ------------------------------
    // Stimulus tasks
    // ------------------------------

    // One fetch, with refill tracking on a miss
    task automatic fetch(input logic [31:0] a, output logic was_hit);
        int exp_way;
        int waited;
        int beats;
        logic [31:0] base;
        exp_way = ref_lookup(a);
        base    = a & ~32'(BLOCKS * 4 - 1);
        @(posedge clock);
        addr <= a;
        rd   <= 1'b1;
        @(negedge clock);
        was_hit = hit;
        if (hit !== (exp_way >= 0)) begin
            report_mismatch($sformatf("hit %b at %h, model expects %b", hit, a, exp_way >= 0));
        end
        if (!hit) begin
            waited = 0;
            while (!busy && waited < TIMEOUT) begin
                @(negedge clock);
                waited++;
            end
            if (!busy) report_timeout("o_busy to rise after a miss");
            else if (waited != 1) begin
                report_mismatch($sformatf("o_busy rose %0d cycles after the miss, expected 1",
                                          waited));
            end
            beats = 0;
            while (busy && beats < TIMEOUT) begin
                if (!mem_re || mem_addr !== base + 32'(4 * beats)) begin
                    report_mismatch($sformatf("beat %0d re %b addr %h, expected %h",
                                              beats, mem_re, mem_addr, base + 32'(4 * beats)));
                end
                beats++;
                @(negedge clock);
            end
            if (busy) report_timeout("o_busy to fall after a refill");
            else if (beats != BLOCKS) begin
                report_mismatch($sformatf("busy for %0d cycles, expected %0d", beats, BLOCKS));
            end
            if (!hit) report_mismatch($sformatf("no hit at %h after refill", a));
        end
        if (exp_way < 0) ref_fill(a);
    endtask

    task automatic flush_all();
        @(posedge clock);
        flush <= 1'b1;
        rd    <= 1'b0;
        @(posedge clock);
        flush <= 1'b0;   // Strobe seen at this edge
        ref_clear();
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before) begin
            $display("test %-20s passed", name);
        end else begin
            tests_failed++;
            $display("test %-20s failed", name);
        end
    endtask

    // ------------------------------
    // Test sequence
    // ------------------------------

    initial begin : stimulus
        logic        was_hit;
        logic [31:0] a;
        logic [31:0] victim_addr;
        logic [31:0] keep_addr;
        int          mark;
        rst_n        = 1'b0;
        addr         = '0;
        rd           = 1'b0;
        flush        = 1'b0;
        error_count  = 0;
        tests_run    = 0;
        tests_failed = 0;
        ref_ptr      = 0;
        rng_state    = 32'd22;
        ref_clear();
        repeat (8) @(posedge clock);
        rst_n <= 1'b1;

        mark = error_count;
        @(negedge clock);
        if (busy !== 1'b0 || mem_re !== 1'b0) report_mismatch("busy or mem_re high after reset");
        fetch(32'h100, was_hit);
        if (was_hit) report_mismatch("first read hit an empty cache");
        finish_test("reset_first_miss", mark);

        mark = error_count;
        fetch(32'h208, was_hit);   // Mid-line word, refill starts at word 0
        if (was_hit) report_mismatch("read of a new line hit");
        finish_test("refill_sequence", mark);

        mark = error_count;
        for (int k = 0; k < BLOCKS; k++) begin
            fetch(32'h100 + 32'(4 * k), was_hit);
            if (!was_hit || busy) report_mismatch("resident word missed or stalled");
        end
        finish_test("line_resident", mark);

        // Three tags on index 3
        mark = error_count;
        fetch(32'h1030, was_hit);
        fetch(32'h2030, was_hit);
        fetch(32'h1030, was_hit);
        if (!was_hit) report_mismatch("first tag lost with two ways");
        fetch(32'h2030, was_hit);
        if (!was_hit) report_mismatch("second tag lost with two ways");
        victim_addr = (ref_tag[ref_ptr][index_of(32'h3030)] == tag_of(32'h1030))
                      ? 32'h1030 : 32'h2030;
        keep_addr   = (victim_addr == 32'h1030) ? 32'h2030 : 32'h1030;
        fetch(32'h3030, was_hit);
        fetch(keep_addr, was_hit);
        if (!was_hit) report_mismatch("non-victim tag evicted");
        fetch(victim_addr, was_hit);
        if (was_hit) report_mismatch("victim tag still resident");
        finish_test("round_robin_evict", mark);

        mark = error_count;
        flush_all();
        fetch(32'h100, was_hit);
        if (was_hit) report_mismatch("read hit after flush");
        finish_test("flush", mark);

        // Small window so lines get reused and evicted
        mark = error_count;
        repeat (200) begin
            rng_state = lcg_next(rng_state);
            a = (rng_state >> 8) & 32'h3FC;
            fetch(a, was_hit);
        end
        finish_test("random_reads", mark);

        $display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
        if (error_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

//--- test/main_memory_model.sv
`timescale 1ns/100ps

module main_memory_model (
    input  cpu_pkg::inst_addr_t i_addr,   // Byte address from the cache
    input  logic                i_re,     // Read strobe
    output cpu_pkg::inst_t      o_data    // Word, no latency
);

    import cpu_pkg::*;

    inst_addr_t word_addr;   // Byte bits dropped

    // ------------------------------
    // Contents
    // ------------------------------

    // Every word is a scramble of its word address
    assign word_addr = i_addr >> 2;

    // Golden-ratio multiply spreads neighbouring words apart
    assign o_data = i_re ? ((word_addr * 32'h9E3779B1) ^ 32'hA5A5A5A5)
                         : '0;    // Quiet bus when idle

endmodule
